/* Bender.yml */
package:
  name: mips_id

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/id_pkg.sv
      - hw/id_field_latch.sv
      - hw/id_ctrl_decode.sv
      - hw/id_operand_gen.sv
      - hw/inst_decode.sv
  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/tb_inst_decode.sv

/* hw/id_ctrl_decode.sv */
// Control decoder for the decode stage
// Opcode and funct to the EX, MEM and WB control bundle, enables gated by valid

`timescale 1ns/1ps
`include "id_macros.svh"

module id_ctrl_decode (
    input  logic                 valid,
    input  id_pkg::inst_fields_t fields,
    output id_pkg::id_ctrl_t     ctrl
);
    import id_pkg::*;

    id_ctrl_t dec;

    ////////////////////////////////////////
    // Opcode and funct decode
    ////////////////////////////////////////
    always_comb begin
        // Idle bundle: NOP, sign kind, nothing enabled
        dec = '0;

        case (fields.opcode)
            OP_SPECIAL: begin
                // R-type writes rd
                dec.reg_write = 1'b1;
                dec.wr_addr   = fields.low.r.rd;
                case (fields.low.r.funct)
                    FN_ADD, FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:          dec.alu_op = ALU_AND;
                    FN_OR:           dec.alu_op = ALU_OR;
                    FN_XOR:          dec.alu_op = ALU_XOR;
                    FN_NOR:          dec.alu_op = ALU_NOR;
                    FN_SLT:          dec.alu_op = ALU_SLT;
                    FN_SLTU:         dec.alu_op = ALU_SLTU;
                    FN_SLL:          dec.alu_op = ALU_SLL;
                    FN_SRL:          dec.alu_op = ALU_SRL;
                    FN_SRA:          dec.alu_op = ALU_SRA;
                    // Link into rd
                    FN_JALR:         dec.jump = 1'b1;
                    FN_JR: begin
                        dec.jump      = 1'b1;
                        dec.reg_write = 1'b0;
                        dec.wr_addr   = '0;
                    end
                    default: begin
                        dec         = '0;
                        dec.illegal = 1'b1;
                    end
                endcase
            end

            // I-type ALU, result to rt
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.alu_src   = 1'b1;
                dec.reg_write = 1'b1;
                dec.wr_addr   = fields.rt;
                case (fields.opcode)
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    OP_LUI:   dec.alu_op = ALU_LUI;
                    default:  dec.alu_op = ALU_ADD;
                endcase
                // Logical immediates are unsigned
                if (fields.opcode inside {OP_ANDI, OP_ORI, OP_XORI})
                    dec.imm_kind = IMM_ZERO;
                else if (fields.opcode == OP_LUI)
                    dec.imm_kind = IMM_UPPER;
            end

            // Address is base plus offset
            OP_LW: begin
                dec.alu_op    = ALU_ADD;
                dec.alu_src   = 1'b1;
                dec.reg_write = 1'b1;
                dec.wr_addr   = fields.rt;
                dec.mem_read  = 1'b1;
            end
            OP_SW: begin
                dec.alu_op    = ALU_ADD;
                dec.alu_src   = 1'b1;
                dec.mem_write = 1'b1;
            end

            // Compare by subtraction
            OP_BEQ, OP_BNE: begin
                dec.alu_op = ALU_SUB;
                dec.branch = 1'b1;
            end

            OP_J: dec.jump = 1'b1;
            OP_JAL: begin
                dec.jump      = 1'b1;
                dec.reg_write = 1'b1;
                dec.wr_addr   = reg_addr_t'(`ID_LINK_REG);
            end

            default: dec.illegal = 1'b1;
        endcase
    end

    ////////////////////////////////////////
    // Validity gating
    ////////////////////////////////////////
    always_comb begin
        ctrl = dec;
        if (!valid) begin
            ctrl.reg_write = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.branch    = 1'b0;
            ctrl.jump      = 1'b0;
            ctrl.illegal   = 1'b0;
        end
    end

endmodule

/* hw/id_field_latch.sv */
// Decode stage input register
// Captures instruction and PC on the strobe and splits the word into fields

`timescale 1ns/1ps

module id_field_latch (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  id_pkg::word_t        instruction,
    input  id_pkg::word_t        pc,
    output logic                 out_valid,
    output id_pkg::inst_fields_t fields,
    output id_pkg::word_t        held_pc
);
    import id_pkg::*;

    word_t inst_q;
    word_t pc_q;

    // Strobe goes through one stage, payload held when idle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            inst_q    <= '0;
            pc_q      <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                inst_q <= instruction;
                pc_q   <= pc;
            end
        end
    end

    // MIPS field positions
    // imm overlays rd, shamt and funct
    always_comb begin
        fields.opcode      = inst_q[31:26];
        fields.rs          = inst_q[25:21];
        fields.rt          = inst_q[20:16];
        fields.low.r.rd    = inst_q[15:11];
        fields.low.r.shamt = inst_q[10:6];
        fields.low.r.funct = inst_q[5:0];
    end

    assign held_pc = pc_q;

endmodule

/* hw/id_macros.svh */
// Instruction decode stage widths and constants
// Shared by the package and the RTL blocks

`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Instruction and data word
`define ID_XLEN 32

// Register file index
`define ID_REG_AW 5

// Immediate field of an I-type word
`define ID_IMM_W 16

// Sequential PC increment
`define ID_PC_STEP 4

// JAL writes the return address here
`define ID_LINK_REG 31

`endif

/* hw/id_operand_gen.sv */
// Operand generator for the decode stage
// Extends the 16-bit immediate by kind and forms the sequential PC

`timescale 1ns/1ps
`include "id_macros.svh"

module id_operand_gen (
    input  logic [`ID_IMM_W-1:0] imm,
    input  id_pkg::imm_kind_e    imm_kind,
    input  id_pkg::word_t        held_pc,
    output id_pkg::word_t        ext_imm,
    output id_pkg::word_t        pc_plus_4
);
    import id_pkg::*;

    localparam int unsigned PAD_W = `ID_XLEN - `ID_IMM_W;

    always_comb begin
        case (imm_kind)
            // ANDI, ORI, XORI
            IMM_ZERO:  ext_imm = {{PAD_W{1'b0}}, imm};
            // LUI, low half cleared
            IMM_UPPER: ext_imm = {imm, {PAD_W{1'b0}}};
            // Arithmetic, loads, stores, branches
            default:   ext_imm = {{PAD_W{imm[`ID_IMM_W-1]}}, imm};
        endcase
    end

    // Wraps past the top of the address space
    assign pc_plus_4 = held_pc + word_t'(`ID_PC_STEP);

endmodule

/* hw/id_pkg.sv */
// Types for the MIPS instruction decode stage
// Opcode and funct encodings, ALU operation, immediate kind, field and
// control bundles

`include "id_macros.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]   word_t;
    typedef logic [`ID_REG_AW-1:0] reg_addr_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Major opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // Funct field under SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    // NOP must stay zero, illegal and idle bundles rely on it
    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // Sign extension is the zero value
    typedef enum logic [1:0] {
        IMM_SIGN, IMM_ZERO, IMM_UPPER
    } imm_kind_e;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Low half seen as R-type fields
    typedef struct packed {
        reg_addr_t rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_low_t;

    // Same 16 bits, R-type view or immediate view
    typedef union packed {
        r_low_t                r;
        logic [`ID_IMM_W-1:0] imm;
    } inst_low_t;

    // Whole instruction word, MIPS bit order
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        inst_low_t  low;
    } inst_fields_t;

    // Control for EX, MEM and WB
    typedef struct packed {
        alu_op_e   alu_op;
        imm_kind_e imm_kind;
        logic      alu_src;
        logic      reg_write;
        reg_addr_t wr_addr;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      jump;
        logic      illegal;
    } id_ctrl_t;

endpackage

/* hw/inst_decode.sv */
// MIPS instruction decode stage, top level
// One cycle from strobe to fields, control bundle, immediate and PC plus four

`timescale 1ns/1ps

module inst_decode (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 in_valid,
    input  id_pkg::word_t        instruction,
    input  id_pkg::word_t        pc,
    output logic                 out_valid,
    output id_pkg::inst_fields_t fields,
    output id_pkg::id_ctrl_t     ctrl,
    output id_pkg::word_t        ext_imm,
    output id_pkg::word_t        pc_plus_4
);
    import id_pkg::*;

    // PC of the instruction in decode
    word_t held_pc;

    // Only registered point of the stage
    id_field_latch u_latch (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .instruction (instruction),
        .pc          (pc),
        .out_valid   (out_valid),
        .fields      (fields),
        .held_pc     (held_pc)
    );

    // Combinational from here on
    id_ctrl_decode u_ctrl (
        .valid  (out_valid),
        .fields (fields),
        .ctrl   (ctrl)
    );

    id_operand_gen u_opnd (
        .imm       (fields.low.imm),
        .imm_kind  (ctrl.imm_kind),
        .held_pc   (held_pc),
        .ext_imm   (ext_imm),
        .pc_plus_4 (pc_plus_4)
    );

endmodule

/* mips_id.f */
+incdir+hw
+incdir+verif
hw/id_pkg.sv
hw/id_field_latch.sv
hw/id_ctrl_decode.sv
hw/id_operand_gen.sv
hw/inst_decode.sv
verif/tb_inst_decode.sv

/* verif/id_ref_model.svh */
// Reference model for the instruction decode stage testbench
// Expected fields, control bundle, immediate and PC plus four per word,
// plus small encoding helpers for stimulus

`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// Everything the DUT shows for one instruction
typedef struct packed {
    inst_fields_t fields;
    id_ctrl_t     ctrl;
    word_t        ext_imm;
    word_t        pc_plus_4;
} exp_t;

// Expectation plus the cycle it was driven
typedef struct packed {
    exp_t        exp;
    logic [31:0] cyc;
} item_t;

function automatic logic opcode_ok(input logic [5:0] op);
    return op inside {OP_SPECIAL, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDI, OP_ADDIU,
                      OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};
endfunction

function automatic logic funct_ok(input logic [5:0] fn);
    return fn inside {FN_SLL, FN_SRL, FN_SRA, FN_JR, FN_JALR, FN_ADD, FN_ADDU, FN_SUB,
                      FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
endfunction

function automatic exp_t id_ref(input word_t inst, input word_t addr);
    exp_t       e;
    logic [5:0] op;
    logic [5:0] fn;
    logic [15:0] imm;
    op  = inst[31:26];
    fn  = inst[5:0];
    imm = inst[15:0];
    // Zero bundle is NOP, sign kind, nothing enabled
    e = '0;
    e.fields    = inst;
    e.pc_plus_4 = addr + `ID_PC_STEP;
    if (op == OP_SPECIAL && funct_ok(fn)) begin
        e.ctrl.jump      = fn inside {FN_JR, FN_JALR};
        e.ctrl.reg_write = (fn != FN_JR);
        e.ctrl.wr_addr   = (fn != FN_JR) ? inst[15:11] : '0;
        case (fn)
            FN_ADD, FN_ADDU: e.ctrl.alu_op = ALU_ADD;
            FN_SUB, FN_SUBU: e.ctrl.alu_op = ALU_SUB;
            FN_AND:  e.ctrl.alu_op = ALU_AND;
            FN_OR:   e.ctrl.alu_op = ALU_OR;
            FN_XOR:  e.ctrl.alu_op = ALU_XOR;
            FN_NOR:  e.ctrl.alu_op = ALU_NOR;
            FN_SLT:  e.ctrl.alu_op = ALU_SLT;
            FN_SLTU: e.ctrl.alu_op = ALU_SLTU;
            FN_SLL:  e.ctrl.alu_op = ALU_SLL;
            FN_SRL:  e.ctrl.alu_op = ALU_SRL;
            FN_SRA:  e.ctrl.alu_op = ALU_SRA;
            default: e.ctrl.alu_op = ALU_NOP;
        endcase
    end else if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                            OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
        e.ctrl.alu_src   = 1'b1;
        e.ctrl.reg_write = 1'b1;
        e.ctrl.wr_addr   = inst[20:16];
        case (op)
            OP_SLTI:  e.ctrl.alu_op = ALU_SLT;
            OP_SLTIU: e.ctrl.alu_op = ALU_SLTU;
            OP_ANDI:  e.ctrl.alu_op = ALU_AND;
            OP_ORI:   e.ctrl.alu_op = ALU_OR;
            OP_XORI:  e.ctrl.alu_op = ALU_XOR;
            OP_LUI:   e.ctrl.alu_op = ALU_LUI;
            default:  e.ctrl.alu_op = ALU_ADD;
        endcase
        if (op inside {OP_ANDI, OP_ORI, OP_XORI})
            e.ctrl.imm_kind = IMM_ZERO;
        if (op == OP_LUI)
            e.ctrl.imm_kind = IMM_UPPER;
    end else if (op == OP_LW || op == OP_SW) begin
        e.ctrl.alu_op    = ALU_ADD;
        e.ctrl.alu_src   = 1'b1;
        e.ctrl.mem_read  = (op == OP_LW);
        e.ctrl.mem_write = (op == OP_SW);
        e.ctrl.reg_write = (op == OP_LW);
        e.ctrl.wr_addr   = (op == OP_LW) ? inst[20:16] : '0;
    end else if (op == OP_BEQ || op == OP_BNE) begin
        e.ctrl.alu_op = ALU_SUB;
        e.ctrl.branch = 1'b1;
    end else if (op == OP_J || op == OP_JAL) begin
        e.ctrl.jump      = 1'b1;
        e.ctrl.reg_write = (op == OP_JAL);
        e.ctrl.wr_addr   = (op == OP_JAL) ? reg_addr_t'(`ID_LINK_REG) : '0;
    end else begin
        e.ctrl.illegal = 1'b1;
    end
    // Extension by kind
    case (e.ctrl.imm_kind)
        IMM_ZERO:  e.ext_imm = {16'h0000, imm};
        IMM_UPPER: e.ext_imm = {imm, 16'h0000};
        default:   e.ext_imm = {{16{imm[15]}}, imm};
    endcase
    return e;
endfunction

`endif

/* verif/tb_inst_decode.sv */
// Testbench for the MIPS instruction decode stage
// Directed sweep, immediate kinds, illegal encodings and a random stream,
// each result checked against the reference model one cycle after its strobe

`timescale 1ns/1ps
`include "id_macros.svh"

module tb_inst_decode;
    import id_pkg::*;
    `include "id_ref_model.svh"

    localparam int unsigned SEED       = 56016;
    localparam int unsigned MAX_CYCLES = 1200;

    logic         clk;
    logic         rstn;
    logic         in_valid;
    word_t        instruction;
    word_t        pc;
    logic         out_valid;
    inst_fields_t fields;
    id_ctrl_t     ctrl;
    word_t        ext_imm;
    word_t        pc_plus_4;

    item_t        exp_q[$];
    item_t        head;
    logic [31:0]  cycles;
    int unsigned  errors;
    int unsigned  n_sent;
    int unsigned  n_checked;

    inst_decode u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .instruction (instruction),
        .pc          (pc),
        .out_valid   (out_valid),
        .fields      (fields),
        .ctrl        (ctrl),
        .ext_imm     (ext_imm),
        .pc_plus_4   (pc_plus_4)
    );

    ////////////////////////////////////////
    // Clock and cycle count
    ////////////////////////////////////////
    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial cycles = '0;
    always @(posedge clk) cycles <= cycles + 1;

    // Hard stop on a hung run
    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("Run timed out after %0d cycles, %0d errors", MAX_CYCLES, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error @%0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Random word with a chosen opcode
    function automatic word_t rand_op(input logic [5:0] op);
        word_t w;
        w = $urandom;
        w[31:26] = op;
        return w;
    endfunction

    function automatic word_t with_funct(input logic [5:0] fn);
        word_t w;
        w = rand_op(OP_SPECIAL);
        w[5:0] = fn;
        return w;
    endfunction

    function automatic word_t with_imm(input logic [5:0] op, input logic [15:0] imm);
        word_t w;
        w = rand_op(op);
        w[15:0] = imm;
        return w;
    endfunction

    function automatic word_t rand_pc();
        return $urandom & 32'hFFFF_FFFC;
    endfunction

    function automatic logic [5:0] bad_opcode();
        logic [5:0] op;
        op = 6'($urandom);
        while (opcode_ok(op))
            op = 6'($urandom);
        return op;
    endfunction

    function automatic logic [5:0] bad_funct();
        logic [5:0] fn;
        fn = 6'($urandom);
        while (funct_ok(fn))
            fn = 6'($urandom);
        return fn;
    endfunction

    // Three in four legal, rest anything
    function automatic word_t rand_inst();
        logic [5:0] op;
        word_t      w;
        op = 6'($urandom);
        if ($urandom_range(0, 3) != 0)
            while (!opcode_ok(op))
                op = 6'($urandom);
        w = rand_op(op);
        if (op == OP_SPECIAL && $urandom_range(0, 3) != 0)
            while (!funct_ok(w[5:0]))
                w[5:0] = 6'($urandom);
        return w;
    endfunction

    task automatic drive(input word_t inst, input word_t addr);
        item_t it;
        @(posedge clk);
        in_valid    <= 1'b1;
        instruction <= inst;
        pc          <= addr;
        it.exp = id_ref(inst, addr);
        it.cyc = cycles;
        exp_q.push_back(it);
        n_sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////
    // Mid-cycle sampling, registered outputs settled
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            // Every result counts, matched or not
            n_checked++;
            if (exp_q.size() == 0) begin
                $display("out_valid was high at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                head = exp_q.pop_front();
                // Strobe edge plus one
                check_val("latency", cycles, head.cyc + 2);
                check_val("fields", fields, head.exp.fields);
                check_val("alu_op", ctrl.alu_op, head.exp.ctrl.alu_op);
                check_val("imm_kind", ctrl.imm_kind, head.exp.ctrl.imm_kind);
                check_val("alu_src", ctrl.alu_src, head.exp.ctrl.alu_src);
                check_val("reg_write", ctrl.reg_write, head.exp.ctrl.reg_write);
                check_val("wr_addr", ctrl.wr_addr, head.exp.ctrl.wr_addr);
                check_val("mem_read", ctrl.mem_read, head.exp.ctrl.mem_read);
                check_val("mem_write", ctrl.mem_write, head.exp.ctrl.mem_write);
                check_val("branch", ctrl.branch, head.exp.ctrl.branch);
                check_val("jump", ctrl.jump, head.exp.ctrl.jump);
                check_val("illegal", ctrl.illegal, head.exp.ctrl.illegal);
                check_val("ext_imm", ext_imm, head.exp.ext_imm);
                check_val("pc_plus_4", pc_plus_4, head.exp.pc_plus_4);
            end
        end else if (rstn) begin
            // No result, so no enable
            check_val("out_valid", out_valid, 1'b0);
            check_val("idle enables", {ctrl.reg_write, ctrl.mem_read, ctrl.mem_write,
                                       ctrl.branch, ctrl.jump, ctrl.illegal}, '0);
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int k;
        void'($urandom(SEED));
        errors      = 0;
        n_sent      = 0;
        n_checked   = 0;
        rstn        = 1'b0;
        in_valid    = 1'b0;
        instruction = '0;
        pc          = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        idle(4);

        // Every supported funct and opcode, twice with fresh fields
        repeat (2) begin
            for (k = 0; k < 64; k++)
                if (funct_ok(6'(k)))
                    drive(with_funct(6'(k)), rand_pc());
            for (k = 1; k < 64; k++)
                if (opcode_ok(6'(k)))
                    drive(rand_op(6'(k)), rand_pc());
        end
        idle(2);

        // Immediate kinds with bit 15 set
        drive(with_imm(OP_ANDI, 16'h8000 | 16'($urandom)), rand_pc());
        drive(with_imm(OP_ORI, 16'h8000 | 16'($urandom)), rand_pc());
        drive(with_imm(OP_XORI, 16'h8000 | 16'($urandom)), rand_pc());
        drive(with_imm(OP_LUI, 16'h8000 | 16'($urandom)), rand_pc());
        drive(with_imm(OP_ADDI, 16'h8000 | 16'($urandom)), rand_pc());
        drive(with_imm(OP_LW, 16'h8000 | 16'($urandom)), rand_pc());
        drive(with_imm(OP_BEQ, 16'h8000 | 16'($urandom)), rand_pc());
        // PC wrap at the top
        drive(with_imm(OP_ADDIU, 16'h7FFF), 32'hFFFF_FFFC);
        idle(2);

        // Unused opcodes and SPECIAL functs
        repeat (20) drive(rand_op(bad_opcode()), rand_pc());
        repeat (20) drive(with_funct(bad_funct()), rand_pc());
        idle(3);

        // Random stream, back to back with short gaps
        for (k = 0; k < 500; k++) begin
            drive(rand_inst(), rand_pc());
            if ($urandom_range(0, 3) == 0)
                idle($urandom_range(1, 2));
        end
        // Last result lands one cycle after its strobe
        idle(2);

        if (exp_q.size() != 0) begin
            $display("%0d instructions never produced a result", exp_q.size());
            errors++;
        end
        if (n_checked != n_sent) begin
            $display("Sent %0d instructions but checked %0d results", n_sent, n_checked);
            errors++;
        end
        $display("Checked %0d of %0d instructions, %0d errors", n_checked, n_sent, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
